/* flist.f */
+incdir+hw
hw/hc_pkg.sv
hw/hc_line_buffer.sv
hw/hc_fifo_from_host.sv
hw/hc_fifo_to_host.sv
hw/hc_status_manager.sv
hw/hc_write_arbiter.sv
hw/hc_root.sv
tb/hc_root_tb.sv

/* hw/hc_consts.svh */
`ifndef HC_CONSTS_SVH
`define HC_CONSTS_SVH

// Width of one data line moved between host and client
`define HC_LINE_BITS 64

// Host addresses count whole lines, not bytes
`define HC_ADDR_BITS 32

// Lines in each of the receive and transmit rings
`define HC_RING_LINES 8

// Running ring index, one bit wider than the ring position so that a
// full ring and an empty ring can be told apart
`define HC_IDX_BITS 4

// Read tag width, taken from the low bits of the running receive index
`define HC_TAG_BITS 4

// Entries in each line buffer, and the receive read credit limit
`define HC_BUF_DEPTH 4

`endif

/* hw/hc_fifo_from_host.sv */
`timescale 1ns/1ps
`default_nettype none

`include "hc_consts.svh"

module hc_fifo_from_host
   (
    input  logic               clk,
    input  logic               reset_n,

    input  hc_pkg::t_hc_csr    csr,

    // Host read channel, already registered in the top level
    input  logic               rd_almost_full,
    output hc_pkg::t_hc_rd_req rd_req,
    output logic               rd_req_valid,
    input  hc_pkg::t_hc_rd_rsp rd_rsp,
    input  logic               rd_rsp_valid,

    // Client side
    output hc_pkg::t_hc_line   rx_data,
    output logic               rx_rdy,
    input  logic               rx_enable,

    // One pulse per line taken by the client
    output logic               rx_consumed
    );

    import hc_pkg::*;

    localparam int RING_BITS = $clog2(`HC_RING_LINES);
    localparam int CNT_BITS = $clog2(`HC_BUF_DEPTH + 1);

    // Running index of the next ring slot to read
    logic [`HC_IDX_BITS-1:0] rd_idx;

    // Reads issued whose response has not come back yet
    logic [CNT_BITS-1:0] in_flight;
    logic [CNT_BITS-1:0] buf_count;
    logic [CNT_BITS:0]   used;

    logic issue;
    logic take;
    logic buf_not_empty;

    // --------------------
    // Read issue
    // --------------------

    // Credits cover lines in flight and lines waiting in the buffer, so
    // every response is guaranteed a free buffer slot
    assign used = {1'b0, in_flight} + {1'b0, buf_count};

    // A read goes out while the host has announced lines not yet fetched
    assign issue = csr.enable &&
                   (rd_idx != csr.rx_prod_idx) &&
                   !rd_almost_full &&
                   (used < (CNT_BITS + 1)'(`HC_BUF_DEPTH));

    assign rd_req.addr = csr.rx_base + `HC_ADDR_BITS'(rd_idx[RING_BITS-1:0]);
    assign rd_req.tag = rd_idx[`HC_TAG_BITS-1:0];
    assign rd_req_valid = issue;

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            rd_idx <= '0;
            in_flight <= '0;
        end
        else
        begin
            if (issue)
                rd_idx <= rd_idx + 1'b1;

            case ({issue, rd_rsp_valid})
                2'b10: in_flight <= in_flight + 1'b1;
                2'b01: in_flight <= in_flight - 1'b1;
                default: in_flight <= in_flight;
            endcase
        end
    end

    // --------------------
    // Delivery to client
    // --------------------

    // Responses arrive in request order, so they go straight into the buffer
    hc_line_buffer
      #(
        .t_entry(t_hc_line)
        )
      rx_buf
       (
        .clk(clk),
        .reset_n(reset_n),
        .push(rd_rsp_valid),
        .push_data(rd_rsp.data),
        .pop(take),
        .pop_data(rx_data),
        .not_empty(buf_not_empty),
        .count(buf_count)
        );

    assign rx_rdy = buf_not_empty;
    assign take = rx_enable && buf_not_empty;
    assign rx_consumed = take;

endmodule

`default_nettype wire

/* hw/hc_fifo_to_host.sv */
`timescale 1ns/1ps
`default_nettype none

`include "hc_consts.svh"

module hc_fifo_to_host
   (
    input  logic               clk,
    input  logic               reset_n,

    input  hc_pkg::t_hc_csr    csr,

    // Client side
    input  hc_pkg::t_hc_line   tx_data,
    input  logic               tx_enable,
    output logic               tx_rdy,

    // Request to the write arbiter, held until granted
    output hc_pkg::t_hc_wr_req wr_req,
    output logic               wr_req_pending,
    input  logic               wr_grant,

    // Pulses when a ring write has been handed to the host port
    output logic               tx_written
    );

    import hc_pkg::*;

    localparam int RING_BITS = $clog2(`HC_RING_LINES);
    localparam int CNT_BITS = $clog2(`HC_BUF_DEPTH + 1);

    // Running index of the next transmit ring slot to fill
    logic [`HC_IDX_BITS-1:0] tx_idx;

    logic [CNT_BITS-1:0] buf_count;
    logic                buf_not_empty;
    t_hc_line            head_line;

    // Client lines wait here until the write channel takes them
    hc_line_buffer
      #(
        .t_entry(t_hc_line)
        )
      tx_buf
       (
        .clk(clk),
        .reset_n(reset_n),
        .push(tx_enable),
        .push_data(tx_data),
        .pop(wr_grant),
        .pop_data(head_line),
        .not_empty(buf_not_empty),
        .count(buf_count)
        );

    // The client is held off only by a full buffer
    assign tx_rdy = (buf_count != CNT_BITS'(`HC_BUF_DEPTH));

    // The head line is always the one to write next
    assign wr_req.addr = csr.tx_base + `HC_ADDR_BITS'(tx_idx[RING_BITS-1:0]);
    assign wr_req.data = head_line;
    assign wr_req_pending = buf_not_empty && csr.enable;

    // The status manager counts a line only once its write is granted
    assign tx_written = wr_grant;

    always_ff @(posedge clk)
    begin
        if (!reset_n)
            tx_idx <= '0;
        else if (wr_grant)
            tx_idx <= tx_idx + 1'b1;
    end

endmodule

`default_nettype wire

/* hw/hc_line_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "hc_consts.svh"

module hc_line_buffer
  #(
    parameter type t_entry = logic
    )
   (
    input  logic                                  clk,
    input  logic                                  reset_n,

    input  logic                                  push,
    input  t_entry                                push_data,

    input  logic                                  pop,
    output t_entry                                pop_data,

    output logic                                  not_empty,
    output logic [$clog2(`HC_BUF_DEPTH + 1)-1:0]  count
    );

    localparam int PTR_BITS = $clog2(`HC_BUF_DEPTH);

    // Entry storage, written at the tail and read at the head
    t_entry mem [`HC_BUF_DEPTH];

    logic [PTR_BITS-1:0] wr_ptr;
    logic [PTR_BITS-1:0] rd_ptr;

    // The head entry is visible without a read cycle
    assign pop_data = mem[rd_ptr];
    assign not_empty = (count != '0);

    always_ff @(posedge clk)
    begin
        if (push)
            mem[wr_ptr] <= push_data;
    end

    // Pointers wrap explicitly so the depth need not be a power of two
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end
        else
        begin
            if (push)
                wr_ptr <= (wr_ptr == PTR_BITS'(`HC_BUF_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= (rd_ptr == PTR_BITS'(`HC_BUF_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;

            // Simultaneous push and pop leave the occupancy unchanged
            if (push && !pop)
                count <= count + 1'b1;
            else if (pop && !push)
                count <= count - 1'b1;
        end
    end

endmodule

`default_nettype wire

/* hw/hc_pkg.sv */
`default_nettype none

`include "hc_consts.svh"

package hc_pkg;

    // One data line
    typedef logic [`HC_LINE_BITS-1:0] t_hc_line;

    // Configuration written by the host over CSRs
    typedef struct packed {
        logic [`HC_ADDR_BITS-1:0] rx_base;
        logic [`HC_ADDR_BITS-1:0] tx_base;
        logic [`HC_ADDR_BITS-1:0] status_addr;
        logic                     enable;
        // Receive producer index as last written by the host
        logic [`HC_IDX_BITS-1:0]  rx_prod_idx;
    } t_hc_csr;

    // Read request on the host read channel
    typedef struct packed {
        logic [`HC_ADDR_BITS-1:0] addr;
        logic [`HC_TAG_BITS-1:0]  tag;
    } t_hc_rd_req;

    // Read response, returned by the host in request order
    typedef struct packed {
        t_hc_line                data;
        logic [`HC_TAG_BITS-1:0] tag;
    } t_hc_rd_rsp;

    // Write request on the host write channel
    typedef struct packed {
        logic [`HC_ADDR_BITS-1:0] addr;
        t_hc_line                 data;
    } t_hc_wr_req;

    // Status line content, placed in the low bits of a line
    typedef struct packed {
        logic [`HC_IDX_BITS-1:0] rx_cons_idx;
        logic [`HC_IDX_BITS-1:0] tx_prod_idx;
    } t_hc_status;

endpackage

`default_nettype wire

/* hw/hc_root.sv */
`timescale 1ns/1ps
`default_nettype none

module hc_root
   (
    input  logic               clk,
    input  logic               reset_n,

    input  hc_pkg::t_hc_csr    csr,

    // Host read channel
    output hc_pkg::t_hc_rd_req rd_req,
    output logic               rd_req_valid,
    input  hc_pkg::t_hc_rd_rsp rd_rsp,
    input  logic               rd_rsp_valid,
    input  logic               rd_almost_full,

    // Host write channel
    output hc_pkg::t_hc_wr_req wr_req,
    output logic               wr_req_valid,
    input  logic               wr_almost_full,

    // Client receive side
    output hc_pkg::t_hc_line   rx_data,
    output logic               rx_rdy,
    input  logic               rx_enable,

    // Client transmit side
    input  hc_pkg::t_hc_line   tx_data,
    output logic               tx_rdy,
    input  logic               tx_enable
    );

    import hc_pkg::*;

    // --------------------
    // Host entry registers
    // --------------------

    t_hc_rd_rsp rd_rsp_q;
    logic       rd_rsp_valid_q;
    logic       rd_almost_full_q;
    logic       wr_almost_full_q;

    always_ff @(posedge clk)
    begin
        rd_rsp_q <= rd_rsp;
    end

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            rd_rsp_valid_q <= 1'b0;
            rd_almost_full_q <= 1'b0;
            wr_almost_full_q <= 1'b0;
        end
        else
        begin
            rd_rsp_valid_q <= rd_rsp_valid;
            rd_almost_full_q <= rd_almost_full;
            wr_almost_full_q <= wr_almost_full;
        end
    end

    // --------------------
    // Host output registers
    // --------------------

    t_hc_rd_req rd_req_d;
    logic       rd_req_valid_d;
    t_hc_wr_req wr_req_d;
    logic       wr_req_valid_d;

    // Every signal toward the host leaves from a flop
    always_ff @(posedge clk)
    begin
        rd_req <= rd_req_d;
        wr_req <= wr_req_d;
    end

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            rd_req_valid <= 1'b0;
            wr_req_valid <= 1'b0;
        end
        else
        begin
            rd_req_valid <= rd_req_valid_d;
            wr_req_valid <= wr_req_valid_d;
        end
    end

    // --------------------
    // Module wiring
    // --------------------

    t_hc_wr_req ring_req;
    logic       ring_pending;
    logic       ring_grant;
    t_hc_wr_req status_req;
    logic       status_pending;
    logic       status_grant;
    logic       rx_consumed;
    logic       tx_written;

    hc_fifo_from_host fifo_from_host
       (
        .clk(clk),
        .reset_n(reset_n),
        .csr(csr),
        .rd_almost_full(rd_almost_full_q),
        .rd_req(rd_req_d),
        .rd_req_valid(rd_req_valid_d),
        .rd_rsp(rd_rsp_q),
        .rd_rsp_valid(rd_rsp_valid_q),
        .rx_data(rx_data),
        .rx_rdy(rx_rdy),
        .rx_enable(rx_enable),
        .rx_consumed(rx_consumed)
        );

    hc_fifo_to_host fifo_to_host
       (
        .clk(clk),
        .reset_n(reset_n),
        .csr(csr),
        .tx_data(tx_data),
        .tx_enable(tx_enable),
        .tx_rdy(tx_rdy),
        .wr_req(ring_req),
        .wr_req_pending(ring_pending),
        .wr_grant(ring_grant),
        .tx_written(tx_written)
        );

    hc_status_manager status_manager
       (
        .clk(clk),
        .reset_n(reset_n),
        .csr(csr),
        .rx_consumed(rx_consumed),
        .tx_written(tx_written),
        .wr_req(status_req),
        .wr_req_pending(status_pending),
        .wr_grant(status_grant)
        );

    // Only the write channel is shared, the reader owns the read channel
    hc_write_arbiter write_arb
       (
        .clk(clk),
        .reset_n(reset_n),
        .wr_almost_full(wr_almost_full_q),
        .ring_req(ring_req),
        .ring_pending(ring_pending),
        .status_req(status_req),
        .status_pending(status_pending),
        .ring_grant(ring_grant),
        .status_grant(status_grant),
        .wr_req(wr_req_d),
        .wr_req_valid(wr_req_valid_d)
        );

endmodule

`default_nettype wire

/* hw/hc_status_manager.sv */
`timescale 1ns/1ps
`default_nettype none

`include "hc_consts.svh"

module hc_status_manager
   (
    input  logic               clk,
    input  logic               reset_n,

    input  hc_pkg::t_hc_csr    csr,

    // Index events from the ring reader and writer
    input  logic               rx_consumed,
    input  logic               tx_written,

    // Status-line write, held until granted
    output hc_pkg::t_hc_wr_req wr_req,
    output logic               wr_req_pending,
    input  logic               wr_grant
    );

    import hc_pkg::*;

    // Current indices and the snapshot most recently sent to the host
    t_hc_status cur_status;
    t_hc_status last_status;

    logic start_write;

    // A new write starts only when the previous one has been granted,
    // so changes seen meanwhile are picked up by the next snapshot
    assign start_write = csr.enable && !wr_req_pending && (cur_status != last_status);

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            cur_status <= '0;
            last_status <= '0;
            wr_req_pending <= 1'b0;
        end
        else
        begin
            if (rx_consumed)
                cur_status.rx_cons_idx <= cur_status.rx_cons_idx + 1'b1;
            if (tx_written)
                cur_status.tx_prod_idx <= cur_status.tx_prod_idx + 1'b1;

            if (wr_grant)
                wr_req_pending <= 1'b0;
            else if (start_write)
            begin
                wr_req_pending <= 1'b1;
                last_status <= cur_status;
            end
        end
    end

    // The status sits in the low bits of the line, zeros above
    always_ff @(posedge clk)
    begin
        if (start_write)
        begin
            wr_req.addr <= csr.status_addr;
            wr_req.data <= `HC_LINE_BITS'(cur_status);
        end
    end

endmodule

`default_nettype wire

/* hw/hc_write_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module hc_write_arbiter
   (
    input  logic               clk,
    input  logic               reset_n,

    // Registered throttle from the host write channel
    input  logic               wr_almost_full,

    input  hc_pkg::t_hc_wr_req ring_req,
    input  logic               ring_pending,
    input  hc_pkg::t_hc_wr_req status_req,
    input  logic               status_pending,

    output logic               ring_grant,
    output logic               status_grant,

    // Granted request, toward the output register
    output hc_pkg::t_hc_wr_req wr_req,
    output logic               wr_req_valid
    );

    // Set when the ring writer wins a tie, cleared after it is served
    logic prefer_ring;

    always_comb
    begin
        ring_grant = 1'b0;
        status_grant = 1'b0;

        // Nothing is granted while the host is near full
        if (!wr_almost_full)
        begin
            if (ring_pending && (!status_pending || prefer_ring))
                ring_grant = 1'b1;
            else if (status_pending)
                status_grant = 1'b1;
        end
    end

    assign wr_req = status_grant ? status_req : ring_req;
    assign wr_req_valid = ring_grant || status_grant;

    always_ff @(posedge clk)
    begin
        if (!reset_n)
            prefer_ring <= 1'b1;
        else if (ring_grant)
            prefer_ring <= 1'b0;
        else if (status_grant)
            prefer_ring <= 1'b1;
    end

endmodule

`default_nettype wire

/* tb/hc_root_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "hc_consts.svh"

module hc_root_tb;

    import hc_pkg::*;

    localparam int STIM_WORDS = 64;
    localparam int MAIN_LIMIT = 4000;
    localparam int DRAIN_LIMIT = 600;
    localparam int QUIET_CYCLES = 30;
    localparam int unsigned RING = `HC_RING_LINES;

    localparam logic [`HC_ADDR_BITS-1:0] RX_BASE = 'h1000;
    localparam logic [`HC_ADDR_BITS-1:0] TX_BASE = 'h2000;
    localparam logic [`HC_ADDR_BITS-1:0] STATUS_ADDR = 'h3000;

    // Record kinds in the stimulus file
    localparam logic [3:0] REC_RX = 4'h1;
    localparam logic [3:0] REC_TX = 4'h2;
    localparam logic [3:0] REC_RD_AF = 4'h3;
    localparam logic [3:0] REC_WR_AF = 4'h4;
    localparam logic [3:0] REC_HOLD = 4'h5;

    logic       clk;
    logic       reset_n;
    t_hc_csr    csr;
    t_hc_rd_req rd_req;
    logic       rd_req_valid;
    t_hc_rd_rsp rd_rsp;
    logic       rd_rsp_valid;
    logic       rd_almost_full;
    t_hc_wr_req wr_req;
    logic       wr_req_valid;
    logic       wr_almost_full;
    t_hc_line   rx_data;
    logic       rx_rdy;
    logic       rx_enable;
    t_hc_line   tx_data;
    logic       tx_rdy;
    logic       tx_enable;

    hc_root dut_i
       (
        .clk(clk),
        .reset_n(reset_n),
        .csr(csr),
        .rd_req(rd_req),
        .rd_req_valid(rd_req_valid),
        .rd_rsp(rd_rsp),
        .rd_rsp_valid(rd_rsp_valid),
        .rd_almost_full(rd_almost_full),
        .wr_req(wr_req),
        .wr_req_valid(wr_req_valid),
        .wr_almost_full(wr_almost_full),
        .rx_data(rx_data),
        .rx_rdy(rx_rdy),
        .rx_enable(rx_enable),
        .tx_data(tx_data),
        .tx_rdy(tx_rdy),
        .tx_enable(tx_enable)
        );

    // --------------------
    // Stimulus and host state
    // --------------------

    // One kind nibble above one line of value per record
    logic [`HC_LINE_BITS+3:0] stim_mem [STIM_WORDS];

    t_hc_line    rx_lines[$];
    t_hc_line    tx_lines[$];
    logic [3:0]  win_kind[$];
    int unsigned win_start[$];
    int unsigned win_len[$];
    int unsigned windows_end;

    // Host memory, keyed by line address
    t_hc_line host_mem [logic [`HC_ADDR_BITS-1:0]];

    // Read responses waiting for their due cycle, kept in request order
    t_hc_rd_rsp  rsp_q[$];
    int unsigned due_q[$];
    int unsigned last_due;

    // Responses returned so far, and as they stood one and two cycles ago
    int unsigned rsp_count;
    int unsigned rsp_count_1ago;
    int unsigned rsp_count_2ago;

    int unsigned cycle;
    int unsigned placed;
    int unsigned rd_count;
    int unsigned rx_got;
    int unsigned tx_sent;
    int unsigned tx_seen;
    int unsigned rd_af_age;
    int unsigned wr_af_age;
    int unsigned status_writes;
    t_hc_line    last_status_line;

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // --------------------
    // Reporting and compares
    // --------------------

    task automatic abort_run();
        $display("TESTBENCH FAILED");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic check_line(input t_hc_line got, input t_hc_line exp, input string what);
        if (got !== exp)
        begin
            $display("FAIL at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic check_status(input t_hc_status got, input t_hc_status exp,
                                input string what);
        if (got !== exp)
        begin
            $display("FAIL at %0t ns: %s has rx_cons %0d tx_prod %0d, expected %0d and %0d",
                     $time, what, got.rx_cons_idx, got.tx_prod_idx,
                     exp.rx_cons_idx, exp.tx_prod_idx);
            abort_run();
        end
    endtask

    task automatic check_rd_req(input t_hc_rd_req got, input t_hc_rd_req exp,
                                input string what);
        if (got !== exp)
        begin
            $display("FAIL at %0t ns: %s has address %h tag %0d, expected %h and %0d",
                     $time, what, got.addr, got.tag, exp.addr, exp.tag);
            abort_run();
        end
    endtask

    task automatic check_wr_req(input t_hc_wr_req got, input t_hc_wr_req exp,
                                input string what);
        if (got !== exp)
        begin
            $display("FAIL at %0t ns: %s has address %h data %h, expected %h and %h",
                     $time, what, got.addr, got.data, exp.addr, exp.data);
            abort_run();
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp)
        begin
            $display("FAIL at %0t ns: %s is %b, expected %b", $time, what, got, exp);
            abort_run();
        end
    endtask

    // --------------------
    // Stimulus file
    // --------------------

    task automatic load_stim();
        logic [3:0] kind;
        t_hc_line   value;
        int         i;
        for (i = 0; i < STIM_WORDS; i++)
            stim_mem[i] = '0;
        $readmemh("tb/hc_stim.txt", stim_mem);
        windows_end = 0;
        i = 0;
        // A kind of zero marks the end of the records
        while (i < STIM_WORDS && stim_mem[i][`HC_LINE_BITS+3:`HC_LINE_BITS] != 4'h0)
        begin
            kind = stim_mem[i][`HC_LINE_BITS+3:`HC_LINE_BITS];
            value = stim_mem[i][`HC_LINE_BITS-1:0];
            case (kind)
                REC_RX: rx_lines.push_back(value);
                REC_TX: tx_lines.push_back(value);
                REC_RD_AF, REC_WR_AF, REC_HOLD:
                begin
                    win_kind.push_back(kind);
                    win_start.push_back(value[63:32]);
                    win_len.push_back(value[31:0]);
                    if (value[63:32] + value[31:0] > windows_end)
                        windows_end = value[63:32] + value[31:0];
                end
                default:
                begin
                    $display("Stimulus file has unknown record kind %0h at word %0d", kind, i);
                    abort_run();
                end
            endcase
            i++;
        end
        if (rx_lines.size() == 0 || tx_lines.size() == 0)
        begin
            $display("Stimulus file holds no receive or no transmit lines");
            abort_run();
        end
    endtask

    function automatic bit window_active(input logic [3:0] kind, input int unsigned c);
        bit active;
        active = 1'b0;
        for (int i = 0; i < win_kind.size(); i++)
        begin
            if (win_kind[i] == kind && c >= win_start[i] && c < win_start[i] + win_len[i])
                active = 1'b1;
        end
        return active;
    endfunction

    function automatic bit traffic_done();
        return rx_got == rx_lines.size() && tx_seen == tx_lines.size() && cycle >= windows_end;
    endfunction

    // --------------------
    // Host port model
    // --------------------

    task automatic watch_read_port();
        t_hc_rd_req  exp_req;
        t_hc_rd_rsp  rsp;
        int unsigned delay;
        if (rd_req_valid)
        begin
            // Two cycles of the window may still carry requests already in the pipe
            if (rd_af_age >= 3)
            begin
                $display("FAIL at %0t ns: read request in cycle %0d of rd_almost_full",
                         $time, rd_af_age);
                abort_run();
            end
            if (rd_count >= placed)
            begin
                $display("FAIL at %0t ns: read request %0d for a line not yet placed",
                         $time, rd_count);
                abort_run();
            end
            exp_req.addr = RX_BASE + rd_count % RING;
            exp_req.tag = `HC_TAG_BITS'(rd_count);
            check_rd_req(rd_req, exp_req, "receive read request");
            // Data is captured now, so the slot may be refilled right after
            rsp.data = host_mem[exp_req.addr];
            rsp.tag = rd_req.tag;
            delay = 1 + $urandom % 4;
            if (cycle + delay > last_due)
                last_due = cycle + delay;
            rsp_q.push_back(rsp);
            due_q.push_back(last_due);
            rd_count++;
        end
        // Lines requested but not yet taken never exceed the buffer depth
        if (rd_count - rx_got > `HC_BUF_DEPTH)
        begin
            $display("FAIL at %0t ns: %0d lines requested and not taken, limit is %0d",
                     $time, rd_count - rx_got, `HC_BUF_DEPTH);
            abort_run();
        end
    endtask

    task automatic watch_write_port();
        t_hc_wr_req exp_req;
        if (wr_req_valid)
        begin
            if (wr_af_age >= 3)
            begin
                $display("FAIL at %0t ns: write request in cycle %0d of wr_almost_full",
                         $time, wr_af_age);
                abort_run();
            end
            if (wr_req.addr == STATUS_ADDR)
            begin
                last_status_line = wr_req.data;
                status_writes++;
            end
            else
            begin
                if (tx_seen >= tx_sent)
                begin
                    $display("FAIL at %0t ns: ring write without a client line", $time);
                    abort_run();
                end
                exp_req.addr = TX_BASE + tx_seen % RING;
                exp_req.data = tx_lines[tx_seen];
                check_wr_req(wr_req, exp_req, "transmit ring write");
                host_mem[wr_req.addr] = wr_req.data;
                tx_seen++;
            end
        end
    endtask

    task automatic drive_host();
        logic [`HC_ADDR_BITS-1:0] slot;
        if (due_q.size() > 0 && due_q[0] <= cycle)
        begin
            rd_rsp = rsp_q.pop_front();
            void'(due_q.pop_front());
            rd_rsp_valid = 1'b1;
            rsp_count++;
        end
        else
        begin
            rd_rsp = '0;
            rd_rsp_valid = 1'b0;
        end

        // The host refills a slot only once its previous line has been read
        if (placed < rx_lines.size() && placed - rd_count < RING)
        begin
            slot = RX_BASE + placed % RING;
            host_mem[slot] = rx_lines[placed];
            placed++;
            csr.rx_prod_idx = `HC_IDX_BITS'(placed);
        end
    endtask

    // --------------------
    // Client model
    // --------------------

    task automatic drive_client();
        bit hold;
        hold = window_active(REC_HOLD, cycle);

        // At the end of a hold the reader must sit exactly at its credit limit
        if (hold && !window_active(REC_HOLD, cycle + 1) &&
            placed >= rx_got + `HC_BUF_DEPTH && rd_count - rx_got != `HC_BUF_DEPTH)
        begin
            $display("FAIL at %0t ns: %0d reads pending after the hold, expected %0d",
                     $time, rd_count - rx_got, `HC_BUF_DEPTH);
            abort_run();
        end

        // A response is offered to the client two cycles after the host returns it
        check_flag(rx_rdy, rsp_count_2ago > rx_got, "rx_rdy");
        // A ring write leaves the transmit buffer in the cycle it reaches the port
        check_flag(tx_rdy, tx_sent - tx_seen != `HC_BUF_DEPTH, "tx_rdy");

        rx_enable = 1'b0;
        if (rx_rdy && !hold && ($urandom % 4 != 0))
        begin
            if (rx_got >= rx_lines.size())
            begin
                $display("The client was offered more lines than the host placed");
                abort_run();
            end
            check_line(rx_data, rx_lines[rx_got], "receive line");
            rx_enable = 1'b1;
            rx_got++;
        end

        tx_enable = 1'b0;
        if (tx_rdy && tx_sent < tx_lines.size() && ($urandom % 2 == 0))
        begin
            tx_data = tx_lines[tx_sent];
            tx_enable = 1'b1;
            tx_sent++;
        end
    endtask

    // One clock of the whole environment, always in the same order
    task automatic step_cycle();
        @(posedge clk);
        #1;
        cycle++;
        rd_almost_full = window_active(REC_RD_AF, cycle);
        wr_almost_full = window_active(REC_WR_AF, cycle);
        rd_af_age = rd_almost_full ? rd_af_age + 1 : 0;
        wr_af_age = wr_almost_full ? wr_af_age + 1 : 0;
        rsp_count_2ago = rsp_count_1ago;
        rsp_count_1ago = rsp_count;
        watch_read_port();
        watch_write_port();
        drive_host();
        drive_client();
    endtask

    // --------------------
    // Main sequence
    // --------------------

    initial
    begin
        int unsigned waited;
        int unsigned quiet;
        t_hc_status  got_status;
        t_hc_status  exp_status;

        void'($urandom(94992));
        reset_n = 1'b0;
        csr = '0;
        csr.rx_base = RX_BASE;
        csr.tx_base = TX_BASE;
        csr.status_addr = STATUS_ADDR;
        csr.enable = 1'b1;
        rd_rsp = '0;
        rd_rsp_valid = 1'b0;
        rd_almost_full = 1'b0;
        wr_almost_full = 1'b0;
        rx_enable = 1'b0;
        tx_data = '0;
        tx_enable = 1'b0;
        cycle = 0;
        placed = 0;
        rd_count = 0;
        rx_got = 0;
        tx_sent = 0;
        tx_seen = 0;
        rd_af_age = 0;
        wr_af_age = 0;
        last_due = 0;
        rsp_count = 0;
        rsp_count_1ago = 0;
        rsp_count_2ago = 0;
        status_writes = 0;
        last_status_line = '0;

        load_stim();

        repeat (10) @(posedge clk);
        #1;
        reset_n = 1'b1;
        if (rd_req_valid !== 1'b0 || wr_req_valid !== 1'b0 || rx_rdy !== 1'b0 || tx_rdy !== 1'b1)
        begin
            $display("Outputs are not in their idle state after reset");
            abort_run();
        end

        // Run until every line has crossed in both directions
        waited = 0;
        while (!traffic_done())
        begin
            if (waited >= MAIN_LIMIT)
            begin
                $display("Timeout after %0d cycles, rx %0d of %0d, tx %0d of %0d lines",
                         waited, rx_got, rx_lines.size(), tx_seen, tx_lines.size());
                abort_run();
            end
            step_cycle();
            waited++;
        end

        // Let the last status write leave before judging it
        waited = 0;
        quiet = 0;
        while (quiet < QUIET_CYCLES)
        begin
            if (waited >= DRAIN_LIMIT)
            begin
                $display("Timeout: host port never went quiet after the traffic ended");
                abort_run();
            end
            step_cycle();
            waited++;
            quiet = (wr_req_valid || rd_req_valid) ? 0 : quiet + 1;
        end

        if (status_writes == 0)
        begin
            $display("No status line was ever written to the host");
            abort_run();
        end
        if (rx_rdy !== 1'b0 || rsp_q.size() != 0 || rd_count != rx_lines.size())
        begin
            $display("Receive side holds extra lines or reads after the traffic ended");
            abort_run();
        end

        exp_status.rx_cons_idx = `HC_IDX_BITS'(rx_lines.size());
        exp_status.tx_prod_idx = `HC_IDX_BITS'(tx_lines.size());
        got_status = last_status_line[$bits(t_hc_status)-1:0];
        check_status(got_status, exp_status, "final status line");
        // Everything above the status bits is zero
        check_line(last_status_line, t_hc_line'(exp_status), "final status line padding");

        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* tb/hc_stim.txt */
// Each word is one record kind digit followed by 16 hex digits of value
// Kinds 1 rx line, 2 tx line, 3 read throttle, 4 write throttle, 5 client rx hold
// Window records carry the start cycle in the upper 8 digits and the length in the lower 8
5000000010000001e
3000000220000000a
4000000140000000c
10123456789abcdef
1fedcba9876543210
100000000000000a1
1ffffffffffffffff
18000000000000001
11111222233334444
1deadbeefcafef00d
15555aaaa5555aaaa
10f0f0f0f0f0f0f0f
17654321076543210
1a5a5a5a5a5a5a5a5
10000000100000002
21000000000000001
22000000000000002
2c3c3c3c33c3c3c3c
20000ffff0000ffff
29abcdef012345678
20000000000000000
23141592653589793
22718281828459045
2ffff0000ffff0000
24242424242424242
20123012301230123
